/* common/rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // base opcodes of RV32I, plus the SYSTEM opcode for CSR accesses
    typedef enum logic [6:0] {
        OPC_LUI       = 7'b0110111,
        OPC_AUIPC     = 7'b0010111,
        OPC_JAL       = 7'b1101111,
        OPC_JALR      = 7'b1100111,
        OPC_BRANCH    = 7'b1100011,
        OPC_LOAD      = 7'b0000011,
        OPC_STORE     = 7'b0100011,
        OPC_ARI_ITYPE = 7'b0010011,
        OPC_ARI_RTYPE = 7'b0110011,
        OPC_CSR       = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_COPY_B = 4'd10  // passes operand b through, used by lui
    } alu_op_e;

    // everything the execute stage needs for one instruction
    typedef struct packed {
        word_t     pc;
        word_t     ra;
        word_t     rb;
        word_t     imm;
        alu_op_e   alu_op;
        logic [2:0] funct3;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2_shamt;  // rs2 and the shift amount share this field
        logic      a_sel;      // 0 selects pc, 1 selects ra
        logic      b_sel;      // 0 selects rb, 1 selects imm
        logic      reg_we;
        logic      mem_we;     // stores
        logic      mem_rr;     // loads
        logic      is_jump;
        logic      jump_conditional;
        logic      csr_write;
    } decoded_t;

    // writeback port from a later stage
    typedef struct packed {
        logic      we;
        reg_addr_t wa;
        word_t     wd;
    } wb_t;

endpackage

/* decode/instr_fields.sv */
module instr_fields (
    input  rv_pkg::word_t     instr,
    output rv_pkg::opcode_e   opcode,
    output logic [2:0]        funct3,
    output logic              funct7_5,
    output rv_pkg::reg_addr_t rd,
    output rv_pkg::reg_addr_t rs1,
    output rv_pkg::reg_addr_t rs2_shamt,
    output rv_pkg::word_t     imm
);

    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t imm_j;
    rv_pkg::word_t imm_csr;

    // fixed field positions are shared by all formats
    assign opcode    = rv_pkg::opcode_e'(instr[6:0]);
    assign rd        = instr[11:7];
    assign funct3    = instr[14:12];
    assign rs1       = instr[19:15];
    assign rs2_shamt = instr[24:20];
    assign funct7_5  = instr[30];  // picks sub and sra

    assign imm_i   = {{20{instr[31]}}, instr[31:20]};
    assign imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u   = {instr[31:12], 12'b0};
    assign imm_j   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_csr = {20'b0, instr[31:20]};  // csr number is unsigned

    always_comb begin
        case (opcode)
            rv_pkg::OPC_LUI,
            rv_pkg::OPC_AUIPC:     imm = imm_u;
            rv_pkg::OPC_JAL:       imm = imm_j;
            rv_pkg::OPC_BRANCH:    imm = imm_b;
            rv_pkg::OPC_STORE:     imm = imm_s;
            rv_pkg::OPC_JALR,
            rv_pkg::OPC_LOAD,
            rv_pkg::OPC_ARI_ITYPE: imm = imm_i;
            rv_pkg::OPC_CSR:       imm = imm_csr;
            default:               imm = '0;  // r-type has no immediate
        endcase
    end

endmodule

/* decode/alu_ctrl.sv */
module alu_ctrl (
    input  rv_pkg::opcode_e opcode,
    input  logic [2:0]      funct3,
    input  logic            funct7_5,
    output rv_pkg::alu_op_e alu_op
);

    logic is_rtype;

    assign is_rtype = (opcode == rv_pkg::OPC_ARI_RTYPE);

    always_comb begin
        alu_op = rv_pkg::ALU_ADD;  // address and pc arithmetic
        if (opcode == rv_pkg::OPC_LUI) begin
            alu_op = rv_pkg::ALU_COPY_B;
        end else if (is_rtype || opcode == rv_pkg::OPC_ARI_ITYPE) begin
            case (funct3)
                3'd0: alu_op = (is_rtype && funct7_5) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                3'd1: alu_op = rv_pkg::ALU_SLL;
                3'd2: alu_op = rv_pkg::ALU_SLT;
                3'd3: alu_op = rv_pkg::ALU_SLTU;
                3'd4: alu_op = rv_pkg::ALU_XOR;
                // srai also carries bit 30, so both formats use it here
                3'd5: alu_op = funct7_5 ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'd6: alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

endmodule

/* regfile/reg_file.sv */
module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_pkg::reg_addr_t ra1,
    input  rv_pkg::reg_addr_t ra2,
    output rv_pkg::word_t     rd1,
    output rv_pkg::word_t     rd2,
    input  rv_pkg::wb_t       wb
);

    rv_pkg::word_t regs [rv_pkg::NUM_REGS];
    logic          wr_en;

    assign wr_en = wb.we && (wb.wa != '0);  // x0 is never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.wa] <= wb.wd;
        end
    end

    // same-cycle writes bypass the array so the decode sees the newest value
    always_comb begin
        if (ra1 == '0) begin
            rd1 = '0;
        end else if (wr_en && wb.wa == ra1) begin
            rd1 = wb.wd;
        end else begin
            rd1 = regs[ra1];
        end
        if (ra2 == '0) begin
            rd2 = '0;
        end else if (wr_en && wb.wa == ra2) begin
            rd2 = wb.wd;
        end else begin
            rd2 = regs[ra2];
        end
    end

    a_wa_known: assert property (@(posedge clk) disable iff (!rst_n)
        wb.we |-> !$isunknown(wb.wa));

endmodule

/* decode/decode_read.sv */
module decode_read (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  rv_pkg::word_t    in_instr,
    input  rv_pkg::word_t    in_pc,
    output logic             out_valid,
    input  logic             out_ready,
    output rv_pkg::decoded_t out_data,
    input  logic             flush,
    input  rv_pkg::wb_t      wb
);

    rv_pkg::opcode_e   opcode;
    logic [2:0]        funct3;
    logic              funct7_5;
    rv_pkg::reg_addr_t rd;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2_shamt;
    rv_pkg::word_t     imm;
    rv_pkg::alu_op_e   alu_op;
    rv_pkg::word_t     rd1;
    rv_pkg::word_t     rd2;
    rv_pkg::decoded_t  next_data;
    logic              accept;

    instr_fields instr_fields_i (
        .instr     (in_instr),
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7_5  (funct7_5),
        .rd        (rd),
        .rs1       (rs1),
        .rs2_shamt (rs2_shamt),
        .imm       (imm)
    );

    alu_ctrl alu_ctrl_i (
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7_5 (funct7_5),
        .alu_op   (alu_op)
    );

    reg_file reg_file_i (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (rs1),
        .ra2   (rs2_shamt),
        .rd1   (rd1),
        .rd2   (rd2),
        .wb    (wb)
    );

    // a flush takes the offered word off the producer and drops it
    assign in_ready = !out_valid || out_ready || flush;
    assign accept   = in_valid && in_ready && !flush;

    always_comb begin
        next_data           = '0;
        next_data.pc        = in_pc;
        next_data.ra        = rd1;
        next_data.rb        = rd2;
        next_data.imm       = imm;
        next_data.alu_op    = alu_op;
        next_data.funct3    = funct3;
        next_data.rd        = rd;
        next_data.rs1       = rs1;
        next_data.rs2_shamt = rs2_shamt;
        case (opcode)
            rv_pkg::OPC_LUI: begin
                next_data.b_sel  = 1'b1;
                next_data.reg_we = 1'b1;
            end
            rv_pkg::OPC_AUIPC: begin
                next_data.b_sel  = 1'b1;  // pc plus upper immediate
                next_data.reg_we = 1'b1;
            end
            rv_pkg::OPC_JAL, rv_pkg::OPC_JALR: begin
                next_data.b_sel   = 1'b1;
                next_data.reg_we  = 1'b1;
                next_data.is_jump = 1'b1;
            end
            rv_pkg::OPC_BRANCH: begin
                next_data.b_sel            = 1'b1;  // target is pc plus offset
                next_data.is_jump          = 1'b1;
                next_data.jump_conditional = 1'b1;
            end
            rv_pkg::OPC_LOAD: begin
                next_data.a_sel  = 1'b1;
                next_data.b_sel  = 1'b1;
                next_data.reg_we = 1'b1;
                next_data.mem_rr = 1'b1;
            end
            rv_pkg::OPC_STORE: begin
                next_data.a_sel  = 1'b1;
                next_data.mem_we = 1'b1;
            end
            rv_pkg::OPC_ARI_ITYPE: begin
                next_data.a_sel  = 1'b1;
                next_data.b_sel  = 1'b1;
                next_data.reg_we = 1'b1;
            end
            rv_pkg::OPC_ARI_RTYPE: begin
                next_data.a_sel  = 1'b1;
                next_data.reg_we = 1'b1;
            end
            rv_pkg::OPC_CSR: begin
                next_data.a_sel     = 1'b1;
                next_data.b_sel     = 1'b1;
                next_data.csr_write = 1'b1;
            end
            default: ;  // unknown opcodes leave every enable low
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;  // drained with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_data <= next_data;
        end
    end

    // the bundle must not move while the next stage is stalled
    a_stable_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data));

    a_flush_empties: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !out_valid);

endmodule

/* design/decode_top.sv */
module decode_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    output logic             in_ready,
    input  rv_pkg::word_t    in_instr,
    input  rv_pkg::word_t    in_pc,
    output logic             out_valid,
    input  logic             out_ready,
    output rv_pkg::decoded_t out_data,
    input  logic             flush,
    input  rv_pkg::wb_t      wb
);

    // decode stage with its register file behind it
    decode_read decode_read_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .in_pc     (in_pc),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .flush     (flush),
        .wb        (wb)
    );

endmodule

/* verif/decode_tb.sv */
module decode_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int REC_WORDS = 9;  // kind, instr, pc, wb ctl, wb data, ra, rb, imm, ctrl

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic             in_ready;
    rv_pkg::word_t    in_instr;
    rv_pkg::word_t    in_pc;
    logic             out_valid;
    logic             out_ready;
    rv_pkg::decoded_t out_data;
    logic             flush;
    rv_pkg::wb_t      wb;

    logic [31:0] stim [0:511];
    int          errors;
    int          tests_ok;
    int          tests_bad;
    int          cycles;
    int          limit;
    string       cur_name;

    decode_top decode_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_instr  (in_instr),
        .in_pc     (in_pc),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .flush     (flush),
        .wb        (wb)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, the DUT did not finish the stimulus", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s %s expected %h actual %h", cur_name, name, exp, act);
            errors++;
        end
    endtask

    // alu_op on top, then the flags in struct order
    function automatic logic [31:0] pack_ctrl(input rv_pkg::decoded_t d);
        return {20'd0, d.alu_op, d.a_sel, d.b_sel, d.reg_we, d.mem_we, d.mem_rr,
                d.is_jump, d.jump_conditional, d.csr_write};
    endfunction

    // funct3 and the register indices sit at the same bits in every format
    function automatic logic [31:0] instr_regs(input logic [31:0] instr);
        return {14'd0, instr[14:12], instr[11:7], instr[19:15], instr[24:20]};
    endfunction

    task automatic check_fields(input int base);
        check_val("pc", stim[base+2], out_data.pc);
        check_val("ra", stim[base+5], out_data.ra);
        check_val("rb", stim[base+6], out_data.rb);
        check_val("imm", stim[base+7], out_data.imm);
        check_val("ctrl", stim[base+8], pack_ctrl(out_data));
        check_val("regs", instr_regs(stim[base+1]),
                  {14'd0, out_data.funct3, out_data.rd, out_data.rs1, out_data.rs2_shamt});
    endtask

    // offers one word and returns just after the edge that accepted it
    task automatic send_instr(input int base);
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        in_instr = stim[base+1];
        in_pc    = stim[base+2];
        wb.we    = stim[base+3][8];  // same-cycle writeback rides along
        wb.wa    = stim[base+3][4:0];
        wb.wd    = stim[base+4];
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        wb       = '0;
    endtask

    task automatic run_record(input int base);
        case (stim[base])
            32'd0: begin
                @(posedge clk);
                #2;
                wb.we = 1'b1;
                wb.wa = stim[base+1][4:0];
                wb.wd = stim[base+2];
                @(posedge clk);
                #2;
                wb = '0;
            end
            32'd1: begin
                send_instr(base);
                @(negedge clk);
                while (!out_valid) @(negedge clk);
                check_fields(base);
            end
            32'd2: begin
                send_instr(base);
                out_ready = 1'b0;
                in_valid  = 1'b1;  // this second offer must be dropped too
                flush     = 1'b1;
                @(negedge clk);
                check_val("in_ready", 32'd1, 32'(in_ready));
                @(posedge clk);
                #2;
                flush    = 1'b0;
                in_valid = 1'b0;
                @(negedge clk);
                check_val("out_valid", 32'd0, 32'(out_valid));
                @(negedge clk);
                check_val("out_valid", 32'd0, 32'(out_valid));
                out_ready = 1'b1;
            end
            default: begin
                send_instr(base);
                out_ready = 1'b0;  // hold the new bundle at the output
                repeat (4) begin
                    @(negedge clk);
                    check_val("out_valid", 32'd1, 32'(out_valid));
                    check_val("in_ready", 32'd0, 32'(in_ready));
                    check_fields(base);
                end
                @(posedge clk);
                #2;
                out_ready = 1'b1;
            end
        endcase
    endtask

    initial begin
        int idx;
        int err_before;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        in_pc     = '0;
        out_ready = 1'b1;
        flush     = 1'b0;
        wb        = '0;
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        cycles    = 0;
        for (int i = 0; i < 512; i++) begin
            stim[i] = 32'hffff_ffff;
        end
        $readmemh("verif/decode_stimulus.txt", stim);
        idx = 0;
        while (idx * REC_WORDS < 512 && stim[idx*REC_WORDS] != 32'hffff_ffff) idx++;
        limit = 20 * idx + 20;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        idx   = 0;
        while (stim[idx*REC_WORDS] != 32'hffff_ffff) begin
            cur_name   = $sformatf("line %0d kind %0d", idx, stim[idx*REC_WORDS]);
            err_before = errors;
            run_record(idx * REC_WORDS);
            if (errors == err_before) begin
                tests_ok++;
                $display("test %s ok", cur_name);
            end else begin
                tests_bad++;
                $display("test %s had mismatches", cur_name);
            end
            idx++;
        end
        $display("tests ok %0d, tests failing %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verif/decode_stimulus.txt */
// kind (0 write, 1 instr, 2 flush, 3 stall), instr or wa, pc or wd, wb {we,wa}, wb data
// then expected ra, rb, imm and ctrl {alu_op, a_sel b_sel reg_we mem_we mem_rr jmp cond csr}
0 00000005 12345678 00000000 00000000 00000000 00000000 00000000 00000000
0 00000006 00000100 00000000 00000000 00000000 00000000 00000000 00000000
0 00000000 deadbeef 00000000 00000000 00000000 00000000 00000000 00000000
1 006283b3 00000100 00000000 00000000 12345678 00000100 00000000 000000a0
1 40628433 00000104 00000000 00000000 12345678 00000100 00000000 000001a0
1 006004b3 00000108 00000000 00000000 00000000 00000100 00000000 000000a0
1 006505b3 0000010c 0000010a cafe0000 cafe0000 00000100 00000000 000000a0
1 00629633 00000110 00000000 00000000 12345678 00000100 00000000 000002a0
1 0062a633 00000114 00000000 00000000 12345678 00000100 00000000 000003a0
1 0062b633 00000118 00000000 00000000 12345678 00000100 00000000 000004a0
1 0062c633 0000011c 00000000 00000000 12345678 00000100 00000000 000005a0
1 0062d633 00000120 00000000 00000000 12345678 00000100 00000000 000006a0
1 4062d633 00000124 00000000 00000000 12345678 00000100 00000000 000007a0
1 0062e633 00000128 00000000 00000000 12345678 00000100 00000000 000008a0
1 0062f633 0000012c 00000000 00000000 12345678 00000100 00000000 000009a0
1 ff028613 00000130 00000000 00000000 12345678 00000000 fffffff0 000000e0
1 7ff2a613 00000134 00000000 00000000 12345678 00000000 000007ff 000003e0
1 fff2b613 00000138 00000000 00000000 12345678 00000000 ffffffff 000004e0
1 0f02c613 0000013c 00000000 00000000 12345678 00000000 000000f0 000005e0
1 8002e613 00000140 00000000 00000000 12345678 00000000 fffff800 000008e0
1 0ff2f613 00000144 00000000 00000000 12345678 00000000 000000ff 000009e0
1 00329613 00000148 00000000 00000000 12345678 00000000 00000003 000002e0
1 0042d613 0000014c 00000000 00000000 12345678 00000000 00000004 000006e0
1 4042d613 00000150 00000000 00000000 12345678 00000000 00000404 000007e0
1 abcde637 00000154 00000000 00000000 00000000 00000000 abcde000 00000a60
1 fffff617 00000158 00000000 00000000 00000000 00000000 fffff000 00000060
1 ff9ff0ef 0000015c 00000000 00000000 00000000 00000000 fffffff8 00000064
1 00c280e7 00000160 00000000 00000000 12345678 00000000 0000000c 00000064
1 fe6288e3 00000164 00000000 00000000 12345678 00000100 fffffff0 00000046
1 ffc32603 00000168 00000000 00000000 00000100 00000000 fffffffc 000000e8
1 0062aa23 0000016c 00000000 00000000 12345678 00000100 00000014 00000090
1 f1429673 00000170 00000000 00000000 12345678 00000000 00000f14 000000c1
3 006283b3 00000300 00000000 00000000 12345678 00000100 00000000 000000a0
1 40628433 00000304 00000000 00000000 12345678 00000100 00000000 000001a0
2 006283b3 00000400 00000000 00000000 00000000 00000000 00000000 00000000
1 006004b3 00000404 00000000 00000000 00000000 00000100 00000000 000000a0

/* project.f */
common/rv_pkg.sv
decode/instr_fields.sv
decode/alu_ctrl.sv
regfile/reg_file.sv
decode/decode_read.sv
design/decode_top.sv
verif/decode_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= decode_tb
RTL_TOP   ?= decode_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
